// File: flist.f
hw/spi_reg_pkg.sv
hw/spi_frame_pkg.sv
hw/spi_ctrl_regs.sv
hw/spi_cdc_sync.sv
hw/spi_shift_engine.sv
hw/spi_master_top.sv
tests/tb_spi_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SPI master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_spi_master \
   --Mdir obj_dir -o tb_spi_master

./obj_dir/tb_spi_master > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation passed"
exit 0

// File: tests/tb_spi_master.sv
// SPI master testbench
module tb_spi_master;
   import spi_reg_pkg::*;
   import spi_frame_pkg::*;

   localparam int ready_timeout = 400;

   logic      clk = 1'b0;
   logic      sclk = 1'b0;
   logic      rst_int;
   logic      sel;
   logic      read;
   logic      write;
   spi_addr_t address;
   spi_data_t data_in;
   spi_data_t data_out;
   logic      ss;
   logic      mosi;
   logic      miso;

   // slave model state
   spi_data_t reply_word = '0;
   spi_data_t slave_tx = '0;
   spi_data_t captured = '0;
   int        low_edges = 0;
   logic      ss_prev = 1'b1;

   integer    seed = 99396;
   int        errors;
   int        test_errors;
   int        tests_run;
   int        tests_failed;

   always #2 clk = ~clk;
   always #5 sclk = ~sclk;

   spi_master_top dut0 (
      .clk      (clk),
      .rst_int  (rst_int),
      .sclk     (sclk),
      .sel      (sel),
      .read     (read),
      .write    (write),
      .address  (address),
      .data_in  (data_in),
      .data_out (data_out),
      .ss       (ss),
      .mosi     (mosi),
      .miso     (miso)
   );

   // slave drives miso on falling edges, lsb first
   assign miso = slave_tx[0];

   always @(negedge sclk) begin
      if (ss) begin
         slave_tx <= reply_word;
      end else begin
         slave_tx <= slave_tx >> 1;
      end
   end

   // mosi sampled on rising edges, first bit ends in the lsb
   always @(posedge sclk) begin
      if (!ss && ss_prev) begin
         captured  <= {mosi, 31'b0};
         low_edges <= 1;
      end else if (!ss) begin
         captured  <= {mosi, captured[spi_data_w-1:1]};
         low_edges <= low_edges + 1;
      end
      ss_prev <= ss;
   end

   task automatic check_data(input string name, input spi_data_t got, input spi_data_t exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic reg_write(input spi_addr_t addr, input spi_data_t data);
      @(posedge clk);
      sel     <= 1'b1;
      write   <= 1'b1;
      address <= addr;
      data_in <= data;
      @(posedge clk);
      sel     <= 1'b0;
      write   <= 1'b0;
   endtask

   // data_out is combinational, sampled mid cycle
   task automatic reg_read(input spi_addr_t addr, output spi_data_t data);
      @(posedge clk);
      sel     <= 1'b1;
      read    <= 1'b1;
      address <= addr;
      @(negedge clk);
      data = data_out;
      @(posedge clk);
      sel     <= 1'b0;
      read    <= 1'b0;
   endtask

   task automatic wait_ready(input logic level);
      spi_data_t rd;
      int        polls;
      polls = 0;
      reg_read(addr_ready, rd);
      while (rd[0] !== level && polls < ready_timeout) begin
         reg_read(addr_ready, rd);
         polls++;
      end
      if (rd[0] !== level) begin
         $display("ready did not become %0d within %0d reads", level, ready_timeout);
         test_errors++;
      end
   endtask

   task automatic run_frame(input spi_data_t tx, input spi_data_t reply);
      spi_data_t rd;
      reply_word = reply;
      reg_write(addr_tx, tx);
      wait_ready(1'b0);
      wait_ready(1'b1);
      check_data("captured", captured, tx);
      check_data("ss low edges", spi_data_t'(low_edges), spi_data_t'(cnt_ss_off - cnt_ss_on));
      reg_read(addr_rx, rd);
      check_data("rx", rd, reply);
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, test_errors);
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   task automatic test_reset();
      spi_data_t rd;
      wait_ready(1'b1);
      @(negedge clk);
      check_bit("ss", ss, 1'b1);
      reg_read(addr_ready, rd);
      check_bit("ready", rd[0], 1'b1);
      reg_read(addr_rx, rd);
      check_data("rx", rd, '0);
      reg_read(addr_scratch, rd);
      check_data("scratch", rd, '0);
      reg_read(addr_version, rd);
      check_data("version", rd, spi_version);
      reg_read(spi_addr_t'(6), rd);
      check_data("unmapped", rd, '0);
   endtask

   task automatic test_scratch();
      spi_data_t wr;
      spi_data_t rd;
      int        i;
      for (i = 0; i < 4; i++) begin
         wr = $random(seed);
         reg_write(addr_scratch, wr);
         reg_read(addr_scratch, rd);
         check_data("scratch", rd, wr);
      end
      // read strobe without sel
      @(posedge clk);
      read    <= 1'b1;
      address <= addr_scratch;
      @(negedge clk);
      check_data("data_out", data_out, '0);
      @(posedge clk);
      read    <= 1'b0;
   endtask

   task automatic test_soft_reset();
      spi_data_t rd;
      reg_write(addr_scratch, $random(seed));
      run_frame($random(seed), $random(seed));
      reg_write(addr_soft_rst, '1);
      wait_ready(1'b1);
      reg_read(addr_scratch, rd);
      check_data("scratch", rd, '0);
      reg_read(addr_rx, rd);
      check_data("rx", rd, '0);
      reg_read(addr_ready, rd);
      check_bit("ready", rd[0], 1'b1);
   endtask

   task automatic test_back_to_back();
      int i;
      for (i = 0; i < 4; i++) begin
         run_frame($random(seed), $random(seed));
      end
   endtask

   initial begin
      rst_int      = 1'b1;
      sel          = 1'b0;
      read         = 1'b0;
      write        = 1'b0;
      address      = '0;
      data_in      = '0;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (8) @(posedge clk);
      rst_int <= 1'b0;
      test_reset();
      report_test("reset");
      test_scratch();
      report_test("scratch");
      run_frame($random(seed), $random(seed));
      report_test("transfer");
      test_soft_reset();
      report_test("soft_reset");
      test_back_to_back();
      report_test("back_to_back");
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: hw/spi_master_top.sv
// SPI master top level
module spi_master_top (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  sclk,
   input  logic                  sel,
   input  logic                  read,
   input  logic                  write,
   input  spi_reg_pkg::spi_addr_t address,
   input  spi_reg_pkg::spi_data_t data_in,
   output spi_reg_pkg::spi_data_t data_out,
   output logic                  ss,
   output logic                  mosi,
   input  logic                  miso
);
   import spi_reg_pkg::*;

   // host domain
   spi_data_t tx_word;
   logic      start_tgl;
   logic      rst_ctrl;
   logic      ready_c;
   spi_data_t rx_word_c;

   // sclk domain
   spi_data_t tx_word_s;
   logic      start_s;
   logic      rst_s;
   logic      ready_s;
   spi_data_t rx_word_s;

   spi_ctrl_regs regs0 (
      .clk       (clk),
      .rst_int   (rst_int),
      .sel       (sel),
      .read      (read),
      .write     (write),
      .address   (address),
      .data_in   (data_in),
      .data_out  (data_out),
      .ready_c   (ready_c),
      .rx_word_c (rx_word_c),
      .tx_word   (tx_word),
      .start_tgl (start_tgl),
      .rst_ctrl  (rst_ctrl)
   );

   spi_cdc_sync cdc0 (
      .clk       (clk),
      .sclk      (sclk),
      .rst_ctrl  (rst_ctrl),
      .tx_word   (tx_word),
      .start_tgl (start_tgl),
      .ready_s   (ready_s),
      .rx_word_s (rx_word_s),
      .tx_word_s (tx_word_s),
      .start_s   (start_s),
      .rst_s     (rst_s),
      .ready_c   (ready_c),
      .rx_word_c (rx_word_c)
   );

   spi_shift_engine eng0 (
      .sclk      (sclk),
      .rst_s     (rst_s),
      .start_s   (start_s),
      .tx_word_s (tx_word_s),
      .miso      (miso),
      .ss        (ss),
      .mosi      (mosi),
      .ready_s   (ready_s),
      .rx_word_s (rx_word_s)
   );

endmodule

// File: hw/spi_shift_engine.sv
// SPI shift engine
module spi_shift_engine (
   input  logic                  sclk,
   input  logic                  rst_s,
   input  logic                  start_s,
   input  spi_reg_pkg::spi_data_t tx_word_s,
   input  logic                  miso,
   output logic                  ss,
   output logic                  mosi,
   output logic                  ready_s,
   output spi_reg_pkg::spi_data_t rx_word_s
);
   import spi_reg_pkg::*;
   import spi_frame_pkg::*;

   frame_cnt_t   cnt;
   frame_phase_t phase;
   spi_data_t    tx_shift;
   logic         ss_d;

   // frame counter, parks at cnt_idle
   always_ff @(negedge sclk or posedge rst_s) begin
      if (rst_s) begin
         cnt <= cnt_idle;
      end else if (start_s) begin
         cnt <= '0;
      end else if (cnt != cnt_idle) begin
         cnt <= cnt + frame_cnt_t'(1);
      end
   end

   // phase follows the counter thresholds
   always_ff @(negedge sclk or posedge rst_s) begin
      if (rst_s) begin
         phase <= ph_idle;
      end else if (start_s) begin
         phase <= ph_lead;
      end else begin
         case (phase)
            ph_lead:  if (cnt == cnt_ss_on) phase <= ph_xfer;
            ph_xfer:  if (cnt == cnt_ss_off) phase <= ph_trail;
            ph_trail: if (cnt == cnt_idle) phase <= ph_idle;
            default: ;
         endcase
      end
   end

   // active low select, only during the transfer phase
   assign ss = (phase != ph_xfer);

   // tx shifter, lsb goes out first
   always_ff @(negedge sclk or posedge rst_s) begin
      if (rst_s) begin
         tx_shift <= '0;
      end else if (cnt == cnt_load) begin
         tx_shift <= tx_word_s;
      end else if (!ss) begin
         tx_shift <= tx_shift >> 1;
      end
   end

   assign mosi = tx_shift[0];

   // rx capture on rising edges, first bit ends up in the lsb
   always_ff @(posedge sclk or posedge rst_s) begin
      if (rst_s) begin
         rx_word_s <= '0;
      end else if (!ss) begin
         rx_word_s <= {miso, rx_word_s[spi_data_w-1:1]};
      end
   end

   // ready is ss two rising edges later
   always_ff @(posedge sclk or posedge rst_s) begin
      if (rst_s) begin
         ss_d    <= 1'b1;
         ready_s <= 1'b1;
      end else begin
         ss_d    <= ss;
         ready_s <= ss_d;
      end
   end

endmodule

// File: hw/spi_cdc_sync.sv
// SPI clock domain crossing
module spi_cdc_sync (
   input  logic                  clk,
   input  logic                  sclk,
   input  logic                  rst_ctrl,
   input  spi_reg_pkg::spi_data_t tx_word,
   input  logic                  start_tgl,
   input  logic                  ready_s,
   input  spi_reg_pkg::spi_data_t rx_word_s,
   output spi_reg_pkg::spi_data_t tx_word_s,
   output logic                  start_s,
   output logic                  rst_s,
   output logic                  ready_c,
   output spi_reg_pkg::spi_data_t rx_word_c
);
   import spi_reg_pkg::*;

   logic [1:0] rst_sync;
   logic [2:0] start_sync;
   spi_data_t  tx_meta;
   logic       ready_meta;
   spi_data_t  rx_meta;

   // reset into sclk, asserts at once, releases on the second falling edge
   always_ff @(negedge sclk or posedge rst_ctrl) begin
      if (rst_ctrl) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign rst_s = rst_sync[1];

   // start toggle, two stages plus one for the edge detect
   always_ff @(negedge sclk or posedge rst_ctrl) begin
      if (rst_ctrl) begin
         start_sync <= '0;
      end else begin
         start_sync <= {start_sync[1:0], start_tgl};
      end
   end

   assign start_s = start_sync[2] ^ start_sync[1];

   // tx word, stable long before the engine loads it
   always_ff @(negedge sclk) begin
      tx_meta   <= tx_word;
      tx_word_s <= tx_meta;
   end

   // ready and rx word back into clk
   always_ff @(posedge clk or posedge rst_ctrl) begin
      if (rst_ctrl) begin
         ready_meta <= 1'b0;
         ready_c    <= 1'b0;
         rx_meta    <= '0;
         rx_word_c  <= '0;
      end else begin
         ready_meta <= ready_s;
         ready_c    <= ready_meta;
         rx_meta    <= rx_word_s;
         rx_word_c  <= rx_meta;
      end
   end

endmodule

// File: hw/spi_ctrl_regs.sv
// SPI host register block
module spi_ctrl_regs (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  sel,
   input  logic                  read,
   input  logic                  write,
   input  spi_reg_pkg::spi_addr_t address,
   input  spi_reg_pkg::spi_data_t data_in,
   output spi_reg_pkg::spi_data_t data_out,
   input  logic                  ready_c,
   input  spi_reg_pkg::spi_data_t rx_word_c,
   output spi_reg_pkg::spi_data_t tx_word,
   output logic                  start_tgl,
   output logic                  rst_ctrl
);
   import spi_reg_pkg::*;

   logic      tx_en;
   logic      soft_rst_en;
   logic      scratch_en;
   logic      soft_rst;
   spi_data_t scratch;

   // write decode
   always_comb begin
      tx_en       = 1'b0;
      soft_rst_en = 1'b0;
      scratch_en  = 1'b0;
      if (sel && write) begin
         case (address)
            addr_tx:       tx_en       = 1'b1;
            addr_soft_rst: soft_rst_en = 1'b1;
            addr_scratch:  scratch_en  = 1'b1;
            default: ;
         endcase
      end
   end

   // soft reset, held for a single cycle
   // also set during the external reset so rst_ctrl outlasts it by one clk
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= 1'b1;
      end else if (soft_rst_en && !soft_rst) begin
         soft_rst <= 1'b1;
      end else begin
         soft_rst <= 1'b0;
      end
   end

   assign rst_ctrl = rst_int | soft_rst;

   // tx word and start toggle
   always_ff @(posedge clk or posedge rst_ctrl) begin
      if (rst_ctrl) begin
         tx_word   <= '0;
         start_tgl <= 1'b0;
      end else if (tx_en) begin
         tx_word   <= data_in;
         start_tgl <= ~start_tgl;
      end
   end

   // scratch
   always_ff @(posedge clk or posedge rst_ctrl) begin
      if (rst_ctrl) begin
         scratch <= '0;
      end else if (scratch_en) begin
         scratch <= data_in;
      end
   end

   // read mux, zero when not selected or unmapped
   always_comb begin
      data_out = '0;
      if (sel && read) begin
         case (address)
            addr_ready:   data_out = spi_data_t'(ready_c);
            addr_rx:      data_out = rx_word_c;
            addr_version: data_out = spi_version;
            addr_scratch: data_out = scratch;
            default: ;
         endcase
      end
   end

endmodule

// File: hw/spi_frame_pkg.sv
// SPI frame timing
package spi_frame_pkg;

   // width of the frame counter in the sclk domain
   localparam int frame_cnt_w = 6;

   typedef logic [frame_cnt_w-1:0] frame_cnt_t;

   // counter thresholds, counted in falling sclk edges from start
   // tx word is copied into the shifter here
   localparam frame_cnt_t cnt_load = frame_cnt_t'(8);

   // slave select drops
   localparam frame_cnt_t cnt_ss_on = frame_cnt_t'(15);

   // slave select rises again, 32 cycles after cnt_ss_on
   localparam frame_cnt_t cnt_ss_off = frame_cnt_t'(47);

   // counter parks here between frames
   localparam frame_cnt_t cnt_idle = frame_cnt_t'(63);

   // engine phases
   typedef enum logic [1:0] {
      ph_idle  = 2'd0,
      ph_lead  = 2'd1,
      ph_xfer  = 2'd2,
      ph_trail = 2'd3
   } frame_phase_t;

endpackage

// File: hw/spi_reg_pkg.sv
// SPI master register map
package spi_reg_pkg;

   // host data and address widths
   localparam int spi_data_w = 32;
   localparam int spi_addr_w = 3;

   typedef logic [spi_data_w-1:0] spi_data_t;
   typedef logic [spi_addr_w-1:0] spi_addr_t;

   // register addresses
   // status, bit 0 is high when no frame is in flight
   localparam spi_addr_t addr_ready = spi_addr_t'(0);

   // write starts a frame
   localparam spi_addr_t addr_tx = spi_addr_t'(1);

   // last received word
   localparam spi_addr_t addr_rx = spi_addr_t'(2);

   // write only, self-clearing
   localparam spi_addr_t addr_soft_rst = spi_addr_t'(3);

   // read only
   localparam spi_addr_t addr_version = spi_addr_t'(4);

   // free read/write word for software
   localparam spi_addr_t addr_scratch = spi_addr_t'(5);

   // version word, major in the upper half
   localparam spi_data_t spi_version = spi_data_t'(32'h0001_0003);

endpackage
